//--- tb.f
design/pcie_app_pkg.sv
design/pcie_reset_seq.sv
design/pcie_cfg_sampler.sv
design/pcie_cplerr_logger.sv
design/pcie_app_top.sv
dv/pcie_app_tb_assert.sv
dv/pcie_app_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := pcie_app_tb
FILELIST := tb.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/pcie_app_tb.sv
module pcie_app_tb;

   import pcie_app_pkg::*;

   localparam int CLK_PERIOD      = 100;
   localparam int CFG_WRITES      = 24;
   localparam int ERR_ROUNDS      = 20;
   localparam int EXIT_ROUNDS     = 8;
   // each error round can produce two reports
   localparam int WATCHDOG_CYCLES = 2 * ERR_ROUNDS * 40 + 2000;

   logic        pld_clk;
   logic        reset;
   ltssm_t      ltssm;
   logic        dlup_exit;
   logic        hotrst_exit;
   logic        l2_exit;
   logic        app_rst;
   logic        crst;
   logic        linkdown;
   cfg_bus_t    cfg_bus;
   cfg_status_t cfg_status;
   dword_t      cfg_devcsr;
   cpl_err_t    cpl_err_in;
   err_desc_t   err_desc;
   logic        lmi_ack;
   lmi_req_t    lmi;
   cpl_err_t    cpl_err;

   // reference model
   dword_t      m_devcsr;
   dword_t      m_linkcsr;
   busdev_t     m_busdev;
   cpl_err_t    exp_set_q[$];
   err_desc_t   exp_desc_q[$];
   lmi_addr_t   wr_addr_q[$];
   dword_t      wr_data_q[$];

   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_err_base = 0;
   bit          run_done = 0;

   pcie_app_top dut (.*);

   bind pcie_cplerr_logger pcie_app_tb_assert u_assert (
      .pld_clk (pld_clk),
      .reset   (reset),
      .app_rst (app_rst),
      .lmi     (lmi),
      .lmi_ack (lmi_ack),
      .cpl_err (cpl_err)
   );

   initial begin
      pld_clk = 1'b0;
      forever #(CLK_PERIOD / 2) pld_clk = ~pld_clk;
   end

   task automatic check_eq(string sig, logic [127:0] got, logic [127:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
      end
   endtask

   task automatic report_failure(string what);
      errors++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   task automatic finish_test(string name);
      tests++;
      $display("test %s done, %0d errors", name, errors - test_err_base);
      test_err_base = errors;
   endtask

   function automatic ltssm_t pick_training_code();
      ltssm_t v;
      do begin
         v = ltssm_t'($urandom_range(31));
      end while (v == LTSSM_L0);
      return v;
   endfunction

   function automatic err_desc_t random_desc();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   task automatic check_cfg_outputs();
      cfg_status_t exp;
      exp.max_payload  = m_devcsr[MPS_LSB +: 3];
      exp.max_read_req = m_devcsr[MRRS_LSB +: 3];
      exp.completer_id = m_busdev;
      exp.gen2         = m_linkcsr[GEN2_BIT];
      check_eq("cfg_status", 128'(cfg_status), 128'(exp));
      check_eq("cfg_devcsr", 128'(cfg_devcsr), 128'(m_devcsr));
   endtask

   // one add/ctl pair, held 3 cycles, then compared with the model
   task automatic send_cfg_word(cfg_addr_t a, dword_t d);
      cfg_bus.add    = a;
      cfg_bus.ctl    = d;
      cfg_bus.ctl_wr = ~cfg_bus.ctl_wr;
      if (a == CFG_ADDR_DEVCSR) m_devcsr = d;
      if (a == CFG_ADDR_LINKCSR) m_linkcsr = d;
      if (a == CFG_ADDR_BUSDEV) m_busdev = busdev_t'(d);
      repeat (3) @(negedge pld_clk);
      check_cfg_outputs();
   endtask

   task automatic drive_training(int cycles);
      repeat (cycles) begin
         ltssm = pick_training_code();
         @(negedge pld_clk);
         check_eq("linkdown", 128'(linkdown), 128'(ltssm != LTSSM_L0));
      end
   endtask

   // n counts the L0 edges since ltssm reached L0
   task automatic check_release(logic crst_held);
      int n;
      n = 0;
      while (app_rst && n < RST_HOLD_CYCLES + 3) begin
         @(negedge pld_clk);
         n++;
         check_eq("linkdown", 128'(linkdown), 128'(0));
         if (app_rst) begin
            check_eq("crst", 128'(crst), 128'(crst_held));
         end
      end
      if (app_rst || n > RST_HOLD_CYCLES + 2) begin
         report_failure($sformatf("resets not released after %0d L0 edges", n));
      end
      if (n < RST_HOLD_CYCLES) begin
         report_failure($sformatf("resets released after only %0d L0 edges", n));
      end
      check_eq("crst", 128'(crst), 128'(0));
   endtask

   task automatic wait_reports();
      int n;
      n = 0;
      while (exp_set_q.size() != 0 && n < 200) begin
         @(negedge pld_clk);
         n++;
      end
      if (exp_set_q.size() != 0) begin
         report_failure("timed out waiting for a cpl_err report");
      end
   endtask

   task automatic run_error_round();
      cpl_err_t p1;
      cpl_err_t p2;
      int       n;
      p1         = cpl_err_t'($urandom_range(1, 127));
      err_desc   = random_desc();
      cpl_err_in = p1;
      exp_set_q.push_back(p1);
      exp_desc_q.push_back(err_desc);
      if ((p1 & HDR_LOG_MASK) != '0) begin
         n = 0;
         while (!lmi.wren && n < 20) begin
            @(negedge pld_clk);
            n++;
         end
         if (!lmi.wren) report_failure("no LMI write started for a header-log report");
         // new edges while the header log is being written
         repeat ($urandom_range(3)) @(negedge pld_clk);
         p2         = cpl_err_t'($urandom_range(127));
         err_desc   = random_desc();
         cpl_err_in = p2;
         if ((p2 & ~p1) != '0) begin
            exp_set_q.push_back(p2 & ~p1);
            exp_desc_q.push_back(err_desc);
         end
      end
      wait_reports();
      cpl_err_in = '0;
      repeat (2) @(negedge pld_clk);
   endtask

   // kind 0 dlup_exit, 1 leaves L0, 2 hotrst_exit, 3 l2_exit
   task automatic run_exit_event(int kind);
      int   n;
      logic both;
      both = (kind >= 2);
      case (kind)
         0: dlup_exit = 1'b1;
         1: ltssm = pick_training_code();
         2: hotrst_exit = 1'b1;
         default: l2_exit = 1'b1;
      endcase
      n = 0;
      do begin
         @(negedge pld_clk);
         n++;
         dlup_exit   = 1'b0;
         hotrst_exit = 1'b0;
         l2_exit     = 1'b0;
      end while (!app_rst && n < 3);
      if (!app_rst || n > 2) report_failure("app_rst did not rise within 2 edges of an exit");
      check_eq("crst", 128'(crst), 128'(both));
      m_devcsr  = '0;
      m_linkcsr = '0;
      m_busdev  = '0;
      @(negedge pld_clk);
      check_cfg_outputs();
      drive_training(int'($urandom_range(2, 5)));
      ltssm = LTSSM_L0;
      check_release(both);
   endtask

   // core side of the LMI four-phase handshake
   initial begin : lmi_core
      lmi_ack = 1'b0;
      forever begin
         @(negedge pld_clk);
         if (lmi.wren) begin
            wr_addr_q.push_back(lmi.addr);
            wr_data_q.push_back(lmi.din);
            repeat ($urandom_range(5)) @(negedge pld_clk);
            lmi_ack = 1'b1;
            while (lmi.wren) @(negedge pld_clk);
            lmi_ack = 1'b0;
         end
      end
   end

   initial begin : report_monitor
      cpl_err_t  exp_set;
      err_desc_t exp_desc;
      int        n_wr;
      forever begin
         @(negedge pld_clk);
         if (cpl_err != '0) begin
            if (exp_set_q.size() == 0) begin
               report_failure("cpl_err pulse with no report expected");
            end else begin
               exp_set  = exp_set_q.pop_front();
               exp_desc = exp_desc_q.pop_front();
               check_eq("cpl_err", 128'(cpl_err), 128'(exp_set));
               n_wr = ((exp_set & HDR_LOG_MASK) != '0) ? HDR_LOG_DWORDS : 0;
               if (wr_addr_q.size() != n_wr) begin
                  report_failure($sformatf("%0d LMI writes in a report, expected %0d",
                                           wr_addr_q.size(), n_wr));
               end else begin
                  for (int i = 0; i < n_wr; i++) begin
                     check_eq("lmi.addr", 128'(wr_addr_q[i]),
                              128'(LMI_HDR_LOG_BASE + lmi_addr_t'(4 * i)));
                     check_eq("lmi.din", 128'(wr_data_q[i]), 128'(exp_desc[32 * i +: 32]));
                  end
               end
            end
            wr_addr_q.delete();
            wr_data_q.delete();
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      run_done = 1'b1;
      $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
   end

   // run ended before the stimulus finished
   final begin
      if (!run_done) begin
         $display("run stopped before the tests completed");
         $display("TESTBENCH FAILED");
      end
   end

   initial begin : stimulus
      cfg_addr_t a;
      void'($urandom(32'h3cfe_2d3d));
      reset       = 1'b1;
      ltssm       = '0;
      dlup_exit   = 1'b0;
      hotrst_exit = 1'b0;
      l2_exit     = 1'b0;
      cfg_bus     = '0;
      cpl_err_in  = '0;
      err_desc    = '0;
      m_devcsr    = '0;
      m_linkcsr   = '0;
      m_busdev    = '0;
      repeat (3) @(posedge pld_clk);
      @(negedge pld_clk);

      check_eq("app_rst", 128'(app_rst), 128'(1));
      check_eq("crst", 128'(crst), 128'(1));
      check_eq("linkdown", 128'(linkdown), 128'(1));
      check_eq("lmi.wren", 128'(lmi.wren), 128'(0));
      check_eq("cpl_err", 128'(cpl_err), 128'(0));
      check_cfg_outputs();
      reset = 1'b0;
      finish_test("reset values");

      drive_training(int'($urandom_range(3, 8)));
      ltssm = LTSSM_L0;
      check_release(1'b1);
      finish_test("link-up release");

      repeat (CFG_WRITES) begin
         case ($urandom_range(3))
            0: a = CFG_ADDR_DEVCSR;
            1: a = CFG_ADDR_LINKCSR;
            2: a = CFG_ADDR_BUSDEV;
            default: a = cfg_addr_t'($urandom_range(15));
         endcase
         send_cfg_word(a, $urandom);
      end
      finish_test("config capture");

      repeat (ERR_ROUNDS) run_error_round();
      finish_test("error reports");

      for (int i = 0; i < EXIT_ROUNDS; i++) begin
         send_cfg_word(CFG_ADDR_DEVCSR, $urandom | 32'h1);
         run_exit_event(i < 4 ? i : int'($urandom_range(3)));
      end
      finish_test("exit events");

      run_done = 1'b1;
      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- dv/pcie_app_tb_assert.sv
module pcie_app_tb_assert (
   input logic                    pld_clk,
   input logic                    reset,
   input logic                    app_rst,
   input pcie_app_pkg::lmi_req_t  lmi,
   input logic                    lmi_ack,
   input pcie_app_pkg::cpl_err_t  cpl_err
);

   // request fields hold until the core answers
   a_req_stable: assert property (
      @(posedge pld_clk) disable iff (reset || app_rst)
      (lmi.wren && !lmi_ack) |=> ($stable(lmi.addr) && $stable(lmi.din))
   ) else $error("LMI addr or din changed while wren waited for ack");

   // a new request only once the previous ack is gone
   a_no_rise_on_ack: assert property (
      @(posedge pld_clk) disable iff (reset || app_rst)
      $rose(lmi.wren) |-> !$past(lmi_ack)
   ) else $error("LMI wren rose while ack was still high");

   a_single_pulse: assert property (
      @(posedge pld_clk) disable iff (reset || app_rst)
      (cpl_err != '0) |=> (cpl_err == '0)
   ) else $error("cpl_err held nonzero for two cycles");

endmodule

//--- design/pcie_app_top.sv
module pcie_app_top (
   input  logic                       pld_clk,
   input  logic                       reset,

   // link state and exit events from the core
   input  pcie_app_pkg::ltssm_t       ltssm,
   input  logic                       dlup_exit,
   input  logic                       hotrst_exit,
   input  logic                       l2_exit,
   output logic                       app_rst,
   output logic                       crst,
   output logic                       linkdown,

   // config bus
   input  pcie_app_pkg::cfg_bus_t     cfg_bus,
   output pcie_app_pkg::cfg_status_t  cfg_status,
   output pcie_app_pkg::dword_t       cfg_devcsr,

   // completion errors and LMI
   input  pcie_app_pkg::cpl_err_t     cpl_err_in,
   input  pcie_app_pkg::err_desc_t    err_desc,
   input  logic                       lmi_ack,
   output pcie_app_pkg::lmi_req_t     lmi,
   output pcie_app_pkg::cpl_err_t     cpl_err
);

   pcie_reset_seq u_reset_seq (
      .pld_clk     (pld_clk),
      .reset       (reset),
      .ltssm       (ltssm),
      .dlup_exit   (dlup_exit),
      .hotrst_exit (hotrst_exit),
      .l2_exit     (l2_exit),
      .app_rst     (app_rst),
      .crst        (crst),
      .linkdown    (linkdown)
   );

   // sampler and logger also sit in app_rst
   pcie_cfg_sampler u_cfg_sampler (
      .pld_clk    (pld_clk),
      .reset      (reset),
      .app_rst    (app_rst),
      .cfg_bus    (cfg_bus),
      .cfg_status (cfg_status),
      .cfg_devcsr (cfg_devcsr)
   );

   pcie_cplerr_logger u_cplerr_logger (
      .pld_clk    (pld_clk),
      .reset      (reset),
      .app_rst    (app_rst),
      .cpl_err_in (cpl_err_in),
      .err_desc   (err_desc),
      .lmi_ack    (lmi_ack),
      .lmi        (lmi),
      .cpl_err    (cpl_err)
   );

endmodule

//--- design/pcie_cplerr_logger.sv
module pcie_cplerr_logger (
   input  logic                     pld_clk,
   input  logic                     reset,
   input  logic                     app_rst,
   input  pcie_app_pkg::cpl_err_t   cpl_err_in,
   input  pcie_app_pkg::err_desc_t  err_desc,
   input  logic                     lmi_ack,
   output pcie_app_pkg::lmi_req_t   lmi,
   output pcie_app_pkg::cpl_err_t   cpl_err
);

   import pcie_app_pkg::*;

   localparam int IDX_W = $clog2(HDR_LOG_DWORDS);

   logic             clr;
   cpl_err_t         err_in_q;
   cpl_err_t         rise;
   cpl_err_t         pending;
   logic             capture;

   log_state_t       state;
   logic [IDX_W-1:0] idx;
   cpl_err_t         cap_set;
   err_desc_t        cap_desc;

   logic             wren_q;
   lmi_addr_t        addr_q;
   dword_t           din_q;

   assign clr     = reset | app_rst;
   assign rise    = cpl_err_in & ~err_in_q;
   assign capture = (state == lg_idle) && (pending != '0);

   assign lmi = '{wren: wren_q, addr: addr_q, din: din_q};

   // last input for the edge detector
   always_ff @(posedge pld_clk) begin
      err_in_q <= cpl_err_in;
   end

   // edges in the capture cycle land in the next report
   always_ff @(posedge pld_clk) begin
      if (clr) begin
         pending <= '0;
      end else if (capture) begin
         pending <= rise;
      end else begin
         pending <= pending | rise;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (capture) begin
         cap_set  <= pending;
         cap_desc <= err_desc;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (state == lg_req && !lmi_ack) begin
         addr_q <= LMI_HDR_LOG_BASE + lmi_addr_t'({idx, 2'b00});
         din_q  <= cap_desc[32*idx +: 32];
      end
   end

   always_ff @(posedge pld_clk) begin
      if (clr) begin
         state   <= lg_idle;
         idx     <= '0;
         wren_q  <= 1'b0;
         cpl_err <= '0;
      end else begin
         cpl_err <= '0;
         case (state)
            lg_idle: begin
               idx <= '0;
               if (capture) begin
                  if ((pending & HDR_LOG_MASK) != '0) begin
                     state <= lg_req;
                  end else begin
                     state <= lg_report;
                  end
               end
            end
            lg_req: begin
               // previous ack must be gone first
               if (!lmi_ack) begin
                  wren_q <= 1'b1;
                  state  <= lg_wait_ack;
               end
            end
            lg_wait_ack: begin
               if (lmi_ack) begin
                  wren_q <= 1'b0;
                  state  <= lg_wait_release;
               end
            end
            lg_wait_release: begin
               if (!lmi_ack) begin
                  if (idx == IDX_W'(HDR_LOG_DWORDS - 1)) begin
                     state <= lg_report;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= lg_req;
                  end
               end
            end
            lg_report: begin
               cpl_err <= cap_set;
               state   <= lg_idle;
            end
            default: begin
               state <= lg_idle;
            end
         endcase
      end
   end

endmodule

//--- design/pcie_cfg_sampler.sv
module pcie_cfg_sampler (
   input  logic                       pld_clk,
   input  logic                       reset,
   input  logic                       app_rst,
   input  pcie_app_pkg::cfg_bus_t     cfg_bus,
   output pcie_app_pkg::cfg_status_t  cfg_status,
   output pcie_app_pkg::dword_t       cfg_devcsr
);

   import pcie_app_pkg::*;

   logic      clr;
   logic      ctl_wr_q;
   logic      toggle;
   logic      wr_stb;
   cfg_addr_t add_q;
   dword_t    ctl_q;

   dword_t    devcsr_r;
   dword_t    linkcsr_r;
   busdev_t   busdev_r;

   assign clr    = reset | app_rst;
   assign toggle = cfg_bus.ctl_wr ^ ctl_wr_q;

   // delayed ctl_wr for toggle detection
   always_ff @(posedge pld_clk) begin
      ctl_wr_q <= cfg_bus.ctl_wr;
   end

   always_ff @(posedge pld_clk) begin
      if (clr) begin
         wr_stb <= 1'b0;
      end else begin
         wr_stb <= toggle;
      end
   end

   always_ff @(posedge pld_clk) begin
      if (toggle) begin
         add_q <= cfg_bus.add;
         ctl_q <= cfg_bus.ctl;
      end
   end

   // slot registers, other slots dropped
   always_ff @(posedge pld_clk) begin
      if (clr) begin
         devcsr_r  <= '0;
         linkcsr_r <= '0;
         busdev_r  <= '0;
      end else if (wr_stb) begin
         case (add_q)
            CFG_ADDR_DEVCSR:  devcsr_r  <= ctl_q;
            CFG_ADDR_LINKCSR: linkcsr_r <= ctl_q;
            CFG_ADDR_BUSDEV:  busdev_r  <= ctl_q[$bits(busdev_t)-1:0];
            default: begin
            end
         endcase
      end
   end

   // decoded fields
   always_ff @(posedge pld_clk) begin
      if (clr) begin
         cfg_status <= '0;
         cfg_devcsr <= '0;
      end else begin
         cfg_status.max_payload  <= devcsr_r[MPS_LSB +: 3];
         cfg_status.max_read_req <= devcsr_r[MRRS_LSB +: 3];
         cfg_status.completer_id <= busdev_r;
         cfg_status.gen2         <= linkcsr_r[GEN2_BIT];
         cfg_devcsr              <= devcsr_r;
      end
   end

endmodule

//--- design/pcie_reset_seq.sv
module pcie_reset_seq (
   input  logic                  pld_clk,
   input  logic                  reset,
   input  pcie_app_pkg::ltssm_t  ltssm,
   input  logic                  dlup_exit,
   input  logic                  hotrst_exit,
   input  logic                  l2_exit,
   output logic                  app_rst,
   output logic                  crst,
   output logic                  linkdown
);

   import pcie_app_pkg::*;

   localparam logic [HOLD_CNT_W-1:0] CNT_LAST = HOLD_CNT_W'(RST_HOLD_CYCLES - 1);

   rst_state_t            state;
   logic [HOLD_CNT_W-1:0] l0_cnt;
   logic                  in_l0;

   assign in_l0    = (ltssm == LTSSM_L0);
   assign linkdown = ~in_l0;

   always_ff @(posedge pld_clk) begin
      if (reset) begin
         state   <= rs_hold;
         l0_cnt  <= '0;
         app_rst <= 1'b1;
         crst    <= 1'b1;
      end else if (hotrst_exit || l2_exit) begin
         // core and application both go back into reset
         state   <= rs_hold;
         l0_cnt  <= '0;
         app_rst <= 1'b1;
         crst    <= 1'b1;
      end else if (dlup_exit) begin
         state   <= rs_hold;
         l0_cnt  <= '0;
         app_rst <= 1'b1;
      end else begin
         case (state)
            rs_hold: begin
               state  <= rs_train;
               l0_cnt <= '0;
            end
            rs_train: begin
               // first L0 edge counts as one
               if (in_l0) begin
                  state  <= rs_count;
                  l0_cnt <= HOLD_CNT_W'(1);
               end
            end
            rs_count: begin
               if (!in_l0) begin
                  state  <= rs_train;
                  l0_cnt <= '0;
               end else if (l0_cnt == CNT_LAST) begin
                  state   <= rs_run;
                  app_rst <= 1'b0;
                  crst    <= 1'b0;
               end else begin
                  l0_cnt <= l0_cnt + 1'b1;
               end
            end
            rs_run: begin
               // link lost resets only the application
               if (!in_l0) begin
                  state   <= rs_hold;
                  app_rst <= 1'b1;
               end
            end
            default: begin
               state <= rs_hold;
            end
         endcase
      end
   end

endmodule

//--- design/pcie_app_pkg.sv
package pcie_app_pkg;

   // widths with a meaning
   typedef logic [4:0]   ltssm_t;
   typedef logic [3:0]   cfg_addr_t;
   typedef logic [31:0]  dword_t;
   typedef logic [11:0]  lmi_addr_t;
   typedef logic [12:0]  busdev_t;
   typedef logic [6:0]   cpl_err_t;
   typedef logic [127:0] err_desc_t;

   // time-multiplexed config bus from the core
   typedef struct packed {
      cfg_addr_t add;
      dword_t    ctl;
      logic      ctl_wr;
   } cfg_bus_t;

   // LMI write request with wren as the handshake request
   typedef struct packed {
      logic      wren;
      lmi_addr_t addr;
      dword_t    din;
   } lmi_req_t;

   typedef struct packed {
      logic [2:0] max_payload;
      logic [2:0] max_read_req;
      busdev_t    completer_id;
      logic       gen2;
   } cfg_status_t;

   typedef enum logic [1:0] {
      rs_hold,
      rs_train,
      rs_count,
      rs_run
   } rst_state_t;

   typedef enum logic [2:0] {
      lg_idle,
      lg_req,
      lg_wait_ack,
      lg_wait_release,
      lg_report
   } log_state_t;

   localparam ltssm_t LTSSM_L0        = 5'h0F;
   localparam int     RST_HOLD_CYCLES = 32;
   localparam int     HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES);

   // config bus slots
   localparam cfg_addr_t CFG_ADDR_DEVCSR  = 4'd0;
   localparam cfg_addr_t CFG_ADDR_LINKCSR = 4'd2;
   localparam cfg_addr_t CFG_ADDR_BUSDEV  = 4'd15;

   // field positions in device control and link control/status
   localparam int MPS_LSB  = 5;
   localparam int MRRS_LSB = 12;
   localparam int GEN2_BIT = 17;

   // errors that need the header log written first
   localparam cpl_err_t  HDR_LOG_MASK     = 7'b001_1100;
   localparam lmi_addr_t LMI_HDR_LOG_BASE = 12'h81C;
   localparam int        HDR_LOG_DWORDS   = 4;

endpackage
